//--- src/bbox_pkg.sv
// Bounding box shared types
package bbox_pkg;

    // Fixed-point format of every position value
    // Integer part in [coord_w-1:frac_w], fraction in [frac_w-1:0]
    localparam int coord_w = 24;
    localparam int frac_w  = 10;

    // Signed screen-space coordinate
    typedef logic signed [coord_w-1:0] coord_t;

    // Unsigned color channel, same width as a coordinate
    typedef logic [coord_w-1:0] chan_t;

    // One vertex in screen space
    typedef struct packed {
        coord_t x;
        coord_t y;
        // Depth rides along, the box ignores it
        coord_t z;
    } vertex_t;

    // Triangle as three vertices
    typedef struct packed {
        vertex_t a;
        vertex_t b;
        vertex_t c;
    } triangle_t;

    // Flat RGB color of the triangle
    typedef struct packed {
        chan_t r;
        chan_t g;
        chan_t b;
    } color_t;

    // Payload carried unchanged beside the box
    typedef struct packed {
        triangle_t triangle;
        color_t    color;
    } prim_t;

    // 2D point, used for box corners
    typedef struct packed {
        coord_t x;
        coord_t y;
    } point_t;

    // Axis-aligned box, lower-left and upper-right corners
    typedef struct packed {
        point_t ll;
        point_t ur;
    } box_t;

    // Screen extent, lower edges are always 0
    typedef struct packed {
        coord_t width;
        coord_t height;
    } screen_t;

    // One-hot MSAA code
    // Anything not listed below behaves as 1x
    typedef logic [3:0] msaa_t;

    localparam msaa_t msaa_1x  = 4'b1000;
    localparam msaa_t msaa_4x  = 4'b0100;
    localparam msaa_t msaa_16x = 4'b0010;
    localparam msaa_t msaa_64x = 4'b0001;

    // Output of one clamp lane
    // below and above tell which screen edge the raw value crossed
    typedef struct packed {
        coord_t coord;
        logic   below;
        logic   above;
    } lane_t;

    // Final box plus its valid level
    typedef struct packed {
        box_t box;
        logic valid;
    } result_t;

endpackage

//--- src/bbox_delay.sv
// Stallable register chain
`timescale 1ns/1ns

module bbox_delay #(
    // Number of register stages, at least 1
    parameter int  DEPTH     = 1,
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    // Low freezes every stage
    input  logic     advance,
    input  payload_t din,
    output payload_t dout
);

    // stages[0] takes the input, stages[DEPTH-1] drives the output
    payload_t stages [DEPTH];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                stages[i] <= '0;
            end
        end else if (advance) begin
            stages[0] <= din;
            // Whole chain moves as one, so nothing is lost or doubled on a stall
            for (int i = 1; i < DEPTH; i++) begin
                stages[i] <= stages[i-1];
            end
        end
    end

    assign dout = stages[DEPTH-1];

endmodule

//--- src/bbox_extent.sv
// Triangle extent finder
`timescale 1ns/1ns

module bbox_extent (
    input  bbox_pkg::triangle_t triangle,
    output bbox_pkg::box_t      box
);
    import bbox_pkg::*;

    // Per-axis vertex values, axis 0 is x and axis 1 is y
    coord_t     vals    [2][3];
    // Strict less-than for the pairs ab, ac, bc
    logic       lt_ab   [2];
    logic       lt_ac   [2];
    logic       lt_bc   [2];
    // One-hot picks of the minimum and maximum vertex
    logic [2:0] sel_min [2];
    logic [2:0] sel_max [2];
    coord_t     lo      [2];
    coord_t     hi      [2];

    // AND-OR mux over the three vertices, sel is one-hot
    function automatic coord_t pick(input logic [2:0] sel, input coord_t v0,
                                    input coord_t v1, input coord_t v2);
        pick = ({coord_w{sel[0]}} & v0)
             | ({coord_w{sel[1]}} & v1)
             | ({coord_w{sel[2]}} & v2);
    endfunction

    always_comb begin
        vals[0][0] = triangle.a.x;
        vals[0][1] = triangle.b.x;
        vals[0][2] = triangle.c.x;
        vals[1][0] = triangle.a.y;
        vals[1][1] = triangle.b.y;
        vals[1][2] = triangle.c.y;

        for (int ax = 0; ax < 2; ax++) begin
            // Three compares per axis serve both minimum and maximum
            lt_ab[ax] = vals[ax][0] < vals[ax][1];
            lt_ac[ax] = vals[ax][0] < vals[ax][2];
            lt_bc[ax] = vals[ax][1] < vals[ax][2];

            // Ties fall to the later vertex for the minimum
            sel_min[ax][0] =  lt_ab[ax] &  lt_ac[ax];
            sel_min[ax][1] = ~lt_ab[ax] &  lt_bc[ax];
            sel_min[ax][2] = ~lt_ac[ax] & ~lt_bc[ax];

            // and to the earlier vertex for the maximum
            sel_max[ax][0] = ~lt_ab[ax] & ~lt_ac[ax];
            sel_max[ax][1] =  lt_ab[ax] & ~lt_bc[ax];
            sel_max[ax][2] =  lt_ac[ax] &  lt_bc[ax];

            lo[ax] = pick(sel_min[ax], vals[ax][0], vals[ax][1], vals[ax][2]);
            hi[ax] = pick(sel_max[ax], vals[ax][0], vals[ax][1], vals[ax][2]);
        end
    end

    // Raw corners, not yet floored or clamped
    assign box.ll.x = lo[0];
    assign box.ll.y = lo[1];
    assign box.ur.x = hi[0];
    assign box.ur.y = hi[1];

endmodule

//--- src/bbox_clamp_lane.sv
// Subsample floor and screen clamp lane
`timescale 1ns/1ns

module bbox_clamp_lane (
    input  bbox_pkg::coord_t coord,
    input  bbox_pkg::coord_t limit,
    input  bbox_pkg::msaa_t  msaa,
    output bbox_pkg::lane_t  lane
);
    import bbox_pkg::*;

    // Fraction bits that survive the floor
    logic [frac_w-1:0] keep_mask;
    coord_t            floored;
    logic              below;
    logic              above;

    always_comb begin
        // Sample spacing is 1, 1/2, 1/4 or 1/8 pixel
        case (msaa)
            msaa_4x:  keep_mask = {1'b1, {(frac_w - 1){1'b0}}};
            msaa_16x: keep_mask = {2'b11, {(frac_w - 2){1'b0}}};
            msaa_64x: keep_mask = {3'b111, {(frac_w - 3){1'b0}}};
            // 1x and any illegal code snap to whole pixels
            default:  keep_mask = '0;
        endcase
    end

    // Integer part passes, low fraction bits are cleared
    assign floored = {coord[coord_w-1:frac_w], coord[frac_w-1:0] & keep_mask};

    // Edge tests look at the raw value, not the floored one
    assign below = coord < 0;
    assign above = coord > limit;

    always_comb begin
        lane.below = below;
        lane.above = above;
        if (below) begin
            lane.coord = '0;
        end else if (above) begin
            lane.coord = limit;
        end else begin
            lane.coord = floored;
        end
    end

endmodule

//--- src/bbox_cull.sv
// Box assembly and off-screen cull
`timescale 1ns/1ns

module bbox_cull #(
    // Register stages from lanes to result, at least 1
    parameter int PIPE_DEPTH = 3
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              advance,
    // Order is ll.x, ll.y, ur.x, ur.y
    input  bbox_pkg::lane_t   lanes [4],
    input  logic              in_valid,
    output bbox_pkg::result_t result
);
    import bbox_pkg::*;

    result_t next_result;
    // Box lies wholly outside the screen on some side
    logic    off_screen;

    // Upper-right under the lower edge means the whole box is left of or below the screen
    // Lower-left over the upper edge means the whole box is right of or above it
    assign off_screen = lanes[2].below | lanes[3].below
                      | lanes[0].above | lanes[1].above;

    always_comb begin
        next_result.box.ll.x = lanes[0].coord;
        next_result.box.ll.y = lanes[1].coord;
        next_result.box.ur.x = lanes[2].coord;
        next_result.box.ur.y = lanes[3].coord;
        next_result.valid    = in_valid & ~off_screen;
    end

    // Result chain, matched to the prim chain at the top
    bbox_delay #(
        .DEPTH     (PIPE_DEPTH),
        .payload_t (result_t)
    ) u_result_delay (
        .clk     (clk),
        .rst     (rst),
        .advance (advance),
        .din     (next_result),
        .dout    (result)
    );

endmodule

//--- src/bbox_top.sv
// Triangle bounding box stage
`timescale 1ns/1ns

module bbox_top #(
    // Latency in advancing cycles, at least 1
    parameter int PIPE_DEPTH = 3
) (
    input  logic                clk,
    input  logic                rst,
    // High lets every stage move
    input  logic                advance,
    input  bbox_pkg::triangle_t triangle,
    input  bbox_pkg::color_t    color,
    input  logic                in_valid,
    // Held stable by the host
    input  bbox_pkg::screen_t   screen,
    // Held stable while triangles are in flight
    input  bbox_pkg::msaa_t     msaa,
    output bbox_pkg::prim_t     out_prim,
    output bbox_pkg::result_t   out_result
);
    import bbox_pkg::*;

    box_t  raw_box;
    lane_t lanes [4];
    prim_t in_prim;

    // Min and max per axis, combinational
    bbox_extent u_extent (
        .triangle (triangle),
        .box      (raw_box)
    );

    // One lane per box coordinate
    // Lane index is corner * 2 + axis
    for (genvar corner = 0; corner < 2; corner++) begin : g_corner
        for (genvar axis = 0; axis < 2; axis++) begin : g_axis
            point_t corner_pt;
            coord_t lane_coord;
            coord_t lane_limit;

            assign corner_pt  = (corner == 0) ? raw_box.ll : raw_box.ur;
            assign lane_coord = (axis == 0) ? corner_pt.x : corner_pt.y;
            // Width bounds x, height bounds y
            assign lane_limit = (axis == 0) ? screen.width : screen.height;

            bbox_clamp_lane u_lane (
                .coord (lane_coord),
                .limit (lane_limit),
                .msaa  (msaa),
                .lane  (lanes[corner * 2 + axis])
            );
        end
    end

    // Validity, cull and the result registers
    bbox_cull #(
        .PIPE_DEPTH (PIPE_DEPTH)
    ) u_cull (
        .clk      (clk),
        .rst      (rst),
        .advance  (advance),
        .lanes    (lanes),
        .in_valid (in_valid),
        .result   (out_result)
    );

    assign in_prim.triangle = triangle;
    assign in_prim.color    = color;

    // Triangle and color travel beside the box, same depth
    bbox_delay #(
        .DEPTH     (PIPE_DEPTH),
        .payload_t (prim_t)
    ) u_prim_delay (
        .clk     (clk),
        .rst     (rst),
        .advance (advance),
        .din     (in_prim),
        .dout    (out_prim)
    );

endmodule

//--- include/bbox_tb_model.svh
// Bounding box reference model
`ifndef BBOX_TB_MODEL_SVH
`define BBOX_TB_MODEL_SVH

// Totals for the closing line
int          errors = 0;
int          checks = 0;
// Fibonacci LFSR state, taps 32 22 2 1
logic [31:0] lfsr_state = 32'h364c;

// n fresh random bits, one LFSR step per bit
function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    logic        fb;
    bits = '0;
    for (int i = 0; i < n; i++) begin
        fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        bits       = {bits[30:0], fb};
    end
    return bits;
endfunction

// Fraction bits that survive on each sample grid
function automatic int kept_frac(input msaa_t m);
    case (m)
        msaa_4x:  return 1;
        msaa_16x: return 2;
        msaa_64x: return 3;
        default:  return 0;
    endcase
endfunction

// Smallest or largest of three values
function automatic coord_t extreme3(input coord_t p, input coord_t q, input coord_t r,
                                    input logic want_max);
    coord_t m;
    m = ((q > p) == want_max) ? q : p;
    return ((r > m) == want_max) ? r : m;
endfunction

// Expected lane, grid floor by shifting and the screen clamp on the raw value
function automatic lane_t clamp_ref(input coord_t c, input coord_t limit, input msaa_t m);
    int    drop;
    lane_t l;
    drop    = frac_w - kept_frac(m);
    l.below = c < 0;
    l.above = c > limit;
    l.coord = l.below ? '0 : l.above ? limit : (c >>> drop) <<< drop;
    return l;
endfunction

// Full expected result for one triangle
function automatic result_t expect_result(input triangle_t t, input screen_t s,
                                          input msaa_t m, input logic v);
    lane_t   llx;
    lane_t   lly;
    lane_t   urx;
    lane_t   ury;
    result_t r;
    llx = clamp_ref(extreme3(t.a.x, t.b.x, t.c.x, 1'b0), s.width, m);
    lly = clamp_ref(extreme3(t.a.y, t.b.y, t.c.y, 1'b0), s.height, m);
    urx = clamp_ref(extreme3(t.a.x, t.b.x, t.c.x, 1'b1), s.width, m);
    ury = clamp_ref(extreme3(t.a.y, t.b.y, t.c.y, 1'b1), s.height, m);
    r.box.ll.x = llx.coord;
    r.box.ll.y = lly.coord;
    r.box.ur.x = urx.coord;
    r.box.ur.y = ury.coord;
    // Rejected when the box lies wholly past one screen edge
    r.valid = v & ~(urx.below | ury.below | llx.above | lly.above);
    return r;
endfunction

task automatic compare_result(input int id, input result_t got, input result_t exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("** Error at %0t ns: test %0d out_result got %h expected %h",
                 $time, id, got, exp);
    end else begin
        $display("test %0d out_result ok, valid %0b", id, got.valid);
    end
endtask

task automatic compare_prim(input int id, input prim_t got, input prim_t exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("** Error at %0t ns: test %0d out_prim got %h expected %h",
                 $time, id, got, exp);
    end else begin
        $display("test %0d out_prim ok", id);
    end
endtask

`endif

//--- tb/bbox_tb.sv
// Bounding box stage testbench
`timescale 1ns/1ns

module bbox_tb;
    import bbox_pkg::*;

    localparam int PIPE_DEPTH  = 3;
    localparam int CLK_PERIOD  = 4;
    localparam int RST_CYCLES  = 16;
    localparam int TABLE_LEN   = 20;
    localparam int RAND_CYCLES = 60;
    // Reset, table rows, random cycles with stalls, the drain and some slack
    localparam int RUN_CYCLES  = RST_CYCLES + TABLE_LEN + RAND_CYCLES + PIPE_DEPTH + 8;
    // One pixel in fixed point
    localparam int P           = 1 << frac_w;

    // Table row with inputs and expected result
    typedef struct {
        triangle_t triangle;
        color_t    color;
        msaa_t     msaa;
        screen_t   screen;
        logic      in_valid;
        result_t   expected;
    } entry_t;

    // Result still in flight
    typedef struct {
        prim_t   prim;
        result_t res;
        int      pushed_at;
        int      id;
    } expect_t;

    logic      clk      = 1'b0;
    logic      rst      = 1'b1;
    logic      advance  = 1'b0;
    triangle_t triangle = '0;
    color_t    color    = '0;
    logic      in_valid = 1'b0;
    screen_t   screen   = '0;
    msaa_t     msaa     = msaa_1x;
    prim_t     out_prim;
    result_t   out_result;

    entry_t    stim [TABLE_LEN];
    int        n_stim = 0;
    expect_t   pending [$];
    // Rising edges that moved the pipeline
    int        adv_edges = 0;
    // 100 by 80 pixels
    screen_t   scr = {coord_t'(100 * P), coord_t'(80 * P)};

    `include "bbox_tb_model.svh"

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        if (!rst && advance) begin
            adv_edges <= adv_edges + 1;
        end
    end

    bbox_top #(
        .PIPE_DEPTH (PIPE_DEPTH)
    ) uut (
        .clk        (clk),
        .rst        (rst),
        .advance    (advance),
        .triangle   (triangle),
        .color      (color),
        .in_valid   (in_valid),
        .screen     (screen),
        .msaa       (msaa),
        .out_prim   (out_prim),
        .out_result (out_result)
    );

    function automatic coord_t px(input int whole, input int frac);
        return coord_t'(whole * P + frac);
    endfunction

    // Depth is arbitrary and only checked on out_prim
    function automatic vertex_t vtx(input coord_t x, input coord_t y);
        vertex_t v;
        v.x = x;
        v.y = y;
        v.z = x - y;
        return v;
    endfunction

    function automatic vertex_t pix(input int x, input int y);
        return vtx(px(x, 0), px(y, 0));
    endfunction

    function automatic triangle_t make_tri(input vertex_t a, input vertex_t b, input vertex_t c);
        triangle_t t;
        t.a = a;
        t.b = b;
        t.c = c;
        return t;
    endfunction

    function automatic color_t make_color(input int id);
        color_t c;
        c.r = chan_t'(id * 'h111);
        c.g = chan_t'(~id);
        c.b = chan_t'(id << 12);
        return c;
    endfunction

    // About 128 pixels either side of the origin
    function automatic coord_t rand_coord();
        logic [31:0] bits;
        bits = take_bits(18);
        return {{(coord_w - 18){bits[17]}}, bits[17:0]};
    endfunction

    function automatic triangle_t rand_triangle();
        return make_tri(vtx(rand_coord(), rand_coord()), vtx(rand_coord(), rand_coord()),
                        vtx(rand_coord(), rand_coord()));
    endfunction

    // Expected corners in whole pixels plus one fraction shared by all four
    task automatic add_entry(input triangle_t t, input msaa_t m, input logic v,
                             input int llx, input int lly, input int urx, input int ury,
                             input int frac, input logic ev);
        entry_t e;
        e.triangle          = t;
        e.color             = make_color(n_stim);
        e.msaa              = m;
        e.screen            = scr;
        e.in_valid          = v;
        e.expected.box.ll.x = px(llx, frac);
        e.expected.box.ll.y = px(lly, frac);
        e.expected.box.ur.x = px(urx, frac);
        e.expected.box.ur.y = px(ury, frac);
        e.expected.valid    = ev;
        stim[n_stim] = e;
        n_stim++;
    endtask

    task automatic build_table();
        vertex_t va;
        vertex_t vb;
        vertex_t vc;
        // Whole-pixel floor with the same vertices in all six orders
        va = vtx(px(10, 'h3a5), px(20, 'h100));
        vb = vtx(px(50, 'h200), px(5, 0));
        vc = vtx(px(30, 0), px(60, 'h3ff));
        add_entry(make_tri(va, vb, vc), msaa_1x, 1'b1, 10, 5, 50, 60, 0, 1'b1);
        add_entry(make_tri(va, vc, vb), msaa_1x, 1'b1, 10, 5, 50, 60, 0, 1'b1);
        add_entry(make_tri(vb, va, vc), msaa_1x, 1'b1, 10, 5, 50, 60, 0, 1'b1);
        add_entry(make_tri(vb, vc, va), msaa_1x, 1'b1, 10, 5, 50, 60, 0, 1'b1);
        add_entry(make_tri(vc, va, vb), msaa_1x, 1'b1, 10, 5, 50, 60, 0, 1'b1);
        add_entry(make_tri(vc, vb, va), msaa_1x, 1'b1, 10, 5, 50, 60, 0, 1'b1);
        // Ties on both axes and then all three vertices equal
        add_entry(make_tri(pix(20, 20), pix(20, 40), pix(40, 20)), msaa_1x, 1'b1,
                  20, 20, 40, 40, 0, 1'b1);
        vc = vtx(px(33, 'h100), px(44, 'h200));
        add_entry(make_tri(vc, vc, vc), msaa_1x, 1'b1, 33, 44, 33, 44, 0, 1'b1);
        // Every corner has fraction 3a5, so each grid keeps a different prefix
        va = vtx(px(10, 'h3a5), px(12, 'h3a5));
        vb = vtx(px(40, 'h3a5), px(30, 0));
        vc = vtx(px(25, 0), px(50, 'h3a5));
        add_entry(make_tri(va, vb, vc), msaa_1x, 1'b1, 10, 12, 40, 50, 0, 1'b1);
        add_entry(make_tri(va, vb, vc), msaa_4x, 1'b1, 10, 12, 40, 50, 'h200, 1'b1);
        add_entry(make_tri(va, vb, vc), msaa_16x, 1'b1, 10, 12, 40, 50, 'h300, 1'b1);
        add_entry(make_tri(va, vb, vc), msaa_64x, 1'b1, 10, 12, 40, 50, 'h380, 1'b1);
        // Two bits set so it snaps to whole pixels
        add_entry(make_tri(va, vb, vc), 4'b0110, 1'b1, 10, 12, 40, 50, 0, 1'b1);
        // Crosses all four edges
        add_entry(make_tri(pix(-5, -3), pix(120, 10), pix(50, 90)), msaa_1x, 1'b1,
                  0, 0, 100, 80, 0, 1'b1);
        // Wholly left, below, right and above the screen
        add_entry(make_tri(pix(-30, 10), pix(-10, 20), pix(-20, 40)), msaa_1x, 1'b1,
                  0, 10, 0, 40, 0, 1'b0);
        add_entry(make_tri(pix(10, -30), pix(20, -5), pix(40, -12)), msaa_1x, 1'b1,
                  10, 0, 40, 0, 0, 1'b0);
        add_entry(make_tri(pix(110, 10), pix(130, 20), pix(120, 30)), msaa_1x, 1'b1,
                  100, 10, 100, 30, 0, 1'b0);
        add_entry(make_tri(pix(10, 90), pix(20, 85), pix(30, 95)), msaa_1x, 1'b1,
                  10, 80, 30, 80, 0, 1'b0);
        // Sits exactly on the edges and stays visible
        add_entry(make_tri(pix(0, 0), pix(100, 80), pix(50, 40)), msaa_1x, 1'b1,
                  0, 0, 100, 80, 0, 1'b1);
        // Visible box but no input valid
        add_entry(make_tri(pix(20, 20), pix(20, 40), pix(40, 20)), msaa_1x, 1'b0,
                  20, 20, 40, 40, 0, 1'b0);
    endtask

    // Drives one triangle with advance high and queues what should come out
    task automatic apply(input triangle_t t, input color_t c, input msaa_t m,
                         input screen_t s, input logic v, input result_t exp, input int id);
        expect_t e;
        triangle    = t;
        color       = c;
        msaa        = m;
        screen      = s;
        in_valid    = v;
        advance     = 1'b1;
        e.prim      = {t, c};
        e.res       = exp;
        e.pushed_at = adv_edges;
        e.id        = id;
        pending.push_back(e);
    endtask

    // Checks the oldest entry once it is due at the falling edge where outputs are settled
    task automatic next_cycle();
        expect_t e;
        @(negedge clk);
        if (pending.size() > 0 && adv_edges - pending[0].pushed_at >= PIPE_DEPTH) begin
            e = pending.pop_front();
            compare_result(e.id, out_result, e.res);
            compare_prim(e.id, out_prim, e.prim);
        end
    endtask

    initial begin
        triangle_t t;
        color_t    c;
        logic      v;
        build_table();
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // All stages cleared by reset
        compare_result(0, out_result, '0);
        compare_prim(0, out_prim, '0);
        for (int i = 0; i < TABLE_LEN; i++) begin
            next_cycle();
            apply(stim[i].triangle, stim[i].color, stim[i].msaa, stim[i].screen,
                  stim[i].in_valid, stim[i].expected, i + 1);
        end
        // Random triangles with about one cycle in four stalled
        for (int i = 0; i < RAND_CYCLES; i++) begin
            next_cycle();
            t   = rand_triangle();
            c.r = chan_t'(take_bits(24));
            c.g = chan_t'(take_bits(24));
            c.b = chan_t'(take_bits(24));
            v   = take_bits(3) != 0;
            if (take_bits(2) == 0) begin
                // Fresh data sits on the inputs but must not enter
                advance  = 1'b0;
                triangle = t;
                color    = c;
                in_valid = v;
            end else begin
                apply(t, c, msaa_64x, scr, v, expect_result(t, scr, msaa_64x, v), 100 + i);
            end
        end
        // Drain with idle inputs
        while (pending.size() > 0) begin
            next_cycle();
            advance  = 1'b1;
            in_valid = 1'b0;
        end
        $display("Checks run %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        #(RUN_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d clock cycles", RUN_CYCLES);
        $display("Errors found");
        $finish;
    end

endmodule

//--- sources.f
+incdir+include
src/bbox_pkg.sv
src/bbox_delay.sv
src/bbox_extent.sv
src/bbox_clamp_lane.sv
src/bbox_cull.sv
src/bbox_top.sv
tb/bbox_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = bbox_tb
FILELIST  = sources.f
LOG       = sim.log
PASS_MSG  = No errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
